// File: rtl/ecc_code_pkg.sv
package ecc_code_pkg;

    localparam int DATA_WIDTH   = 109;
    localparam int PARITY_WIDTH = 8;
    localparam int HAMMING_BITS = 7;

    // first position the hamming part can no longer address
    localparam int POS_LIMIT    = 1 << HAMMING_BITS;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    typedef enum logic [1:0] {
        ST_NONE   = 2'b00,
        ST_SINGLE = 2'b01,
        ST_DOUBLE = 2'b10
    } ecc_status_e;

    // syndrome column of data bit idx
    // positions skip the powers of two, which belong to the check bits
    function automatic parity_t data_column(input int idx);
        parity_t col;
        int      seen;
        col  = '0;
        seen = 0;
        for (int pos = 3; pos < POS_LIMIT; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (seen == idx) begin
                    col[HAMMING_BITS-1:0] = pos[HAMMING_BITS-1:0];
                end
                seen++;
            end
        end
        // overall parity bit keeps every column at odd weight
        col[PARITY_WIDTH-1] = ~^col[HAMMING_BITS-1:0];
        return col;
    endfunction

endpackage

// File: rtl/ecc_bus_pkg.sv
package ecc_bus_pkg;

    import ecc_code_pkg::*;

    // request word, check bits as received alongside the data
    typedef struct packed {
        data_t   data;
        parity_t parity_in;
        logic    bypass;
    } ecc_req_t;

    // response word
    typedef struct packed {
        data_t   data;
        parity_t parity_out;
        logic    sbit_err;
        logic    dbit_err;
    } ecc_rsp_t;

    // stage one register contents
    // syndrome is already formed here so stage two only decodes
    typedef struct packed {
        data_t   data;
        parity_t parity_out;
        parity_t syndrome;
        logic    bypass;
    } ecc_stage_t;

endpackage

// File: rtl/ecc_parity_gen.sv
module ecc_parity_gen
    import ecc_code_pkg::*;
(
    input  data_t   data,
    output parity_t parity
);

    // data bits that feed check bit k
    function automatic data_t check_select(input int k);
        data_t   sel;
        parity_t col;
        sel = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            col    = data_column(i);
            sel[i] = col[k];
        end
        return sel;
    endfunction

    // selection masks are constants, so each check bit folds to a fixed xor tree
    for (genvar k = 0; k < PARITY_WIDTH; k++) begin : g_check
        localparam data_t SEL = check_select(k);

        assign parity[k] = ^(data & SEL);
    end

endmodule

// File: rtl/ecc_syndrome_decode.sv
module ecc_syndrome_decode
    import ecc_code_pkg::*;
(
    input  parity_t     syndrome,
    output data_t       mask,
    output ecc_status_e status
);

    data_t hit;
    logic  check_flip;

    // one comparator per data column
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_col
        localparam parity_t COL = data_column(i);

        assign hit[i] = (syndrome == COL);
    end

    // a lone set bit points at a check bit, the data is intact
    assign check_flip = $onehot(syndrome);

    always_comb begin
        mask   = '0;
        status = ST_NONE;
        if (syndrome == '0) begin
            status = ST_NONE;
        end else if (|hit) begin
            mask   = hit;
            status = ST_SINGLE;
        end else if (check_flip) begin
            status = ST_SINGLE;
        end else begin
            // even weight or an unused odd column
            status = ST_DOUBLE;
        end
    end

    // distinct columns keep the mask one-hot
    always_comb begin
        if (!$isunknown(syndrome)) begin
            assert ($onehot0(mask))
            else $error("correction mask has more than one bit set: %h", mask);
            assert (mask == '0 || status == ST_SINGLE)
            else $error("correction mask %h with status %s", mask, status.name());
        end
    end

endmodule

// File: rtl/ecc_109_top.sv
module ecc_109_top
    import ecc_code_pkg::*;
    import ecc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  ecc_req_t req,
    output logic     rsp_valid,
    output ecc_rsp_t rsp
);

    parity_t     parity_calc;
    ecc_stage_t  stage_d;
    ecc_stage_t  stage_q;
    logic        stage_valid;

    data_t       fix_mask;
    ecc_status_e status;
    ecc_rsp_t    rsp_d;

    // stage one: encode the incoming data and form the syndrome

    ecc_parity_gen u_parity_gen (
        .data   (req.data),
        .parity (parity_calc)
    );

    always_comb begin
        stage_d.data       = req.data;
        stage_d.parity_out = parity_calc;
        stage_d.syndrome   = req.parity_in ^ parity_calc;
        stage_d.bypass     = req.bypass;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            stage_q <= stage_d;
        end
    end

    // stage two: decode and correct

    ecc_syndrome_decode u_syndrome_decode (
        .syndrome (stage_q.syndrome),
        .mask     (fix_mask),
        .status   (status)
    );

    always_comb begin
        rsp_d.data       = stage_q.data;
        rsp_d.parity_out = stage_q.parity_out;
        rsp_d.sbit_err   = 1'b0;
        rsp_d.dbit_err   = 1'b0;
        // bypass leaves the word untouched and keeps both flags low
        if (!stage_q.bypass) begin
            rsp_d.data     = stage_q.data ^ fix_mask;
            rsp_d.sbit_err = (status == ST_SINGLE);
            rsp_d.dbit_err = (status == ST_DOUBLE);
        end
    end

    // only the flags are cleared, data and parity_out just hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid    <= 1'b0;
            rsp.sbit_err <= 1'b0;
            rsp.dbit_err <= 1'b0;
        end else begin
            rsp_valid <= stage_valid;
            if (stage_valid) begin
                rsp <= rsp_d;
            end
        end
    end

    // every strobe gives a response two edges later
    a_rsp_follows_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> ##2 rsp_valid
    ) else $error("no response two cycles after request");

    // and no response shows up without one
    a_rsp_has_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(req_valid, 2)
    ) else $error("response without a request two cycles earlier");

    a_flags_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rsp.sbit_err && rsp.dbit_err)
    ) else $error("single and double error flags both set");

    a_bypass_quiet : assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage_valid && stage_q.bypass) |=> (!rsp.sbit_err && !rsp.dbit_err)
    ) else $error("error flag raised on a bypass response");

endmodule

// File: dv/ecc_ref_model.svh
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// syndrome columns of the data bits, filled once at start
parity_t model_cols [DATA_WIDTH];

// positions run upward from 3 and skip every power of two
function automatic void init_model_columns();
    int pos;
    pos = 2;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        pos++;
        while ($countones(pos) == 1) begin
            pos++;
        end
        model_cols[i] = '0;
        model_cols[i][HAMMING_BITS-1:0] = pos[HAMMING_BITS-1:0];
        model_cols[i][PARITY_WIDTH-1] = ($countones(pos[HAMMING_BITS-1:0]) % 2) == 0;
    end
endfunction

function automatic parity_t model_check(input data_t d);
    parity_t p;
    p = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            p[k] = p[k] ^ (model_cols[i][k] & d[i]);
        end
    end
    return p;
endfunction

// expected response for one request
function automatic ecc_rsp_t model_response(input ecc_req_t r);
    ecc_rsp_t e;
    parity_t  syn;
    logic     hit;
    e.data       = r.data;
    e.parity_out = model_check(r.data);
    e.sbit_err   = 1'b0;
    e.dbit_err   = 1'b0;
    syn          = r.parity_in ^ e.parity_out;
    hit          = 1'b0;
    if (!r.bypass && syn != '0) begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (model_cols[i] == syn) begin
                e.data[i] = ~e.data[i];
                hit       = 1'b1;
            end
        end
        // a single set bit is a flipped check bit
        if (hit || $countones(syn) == 1) begin
            e.sbit_err = 1'b1;
        end else begin
            e.dbit_err = 1'b1;
        end
    end
    return e;
endfunction

`endif

// File: dv/ecc_109_tb.sv
module ecc_109_tb
    import ecc_code_pkg::*;
    import ecc_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES   = 4;
    localparam int N_TESTS        = 5;
    localparam int N_PER_TEST     = 40;
    localparam int N_REQ          = N_TESTS * N_PER_TEST;
    localparam int MAX_GAP        = 2;
    localparam int CODE_WIDTH     = DATA_WIDTH + PARITY_WIDTH;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_REQ * 2 + N_REQ * MAX_GAP + 50;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    ecc_req_t req;
    logic     rsp_valid;
    ecc_rsp_t rsp;

    integer   seed;
    int       req_kind;
    int       cyc = 0;
    int       errors;
    int       checks;

    ecc_rsp_t exp_q [$];
    int       due_q [$];
    int       kind_q [$];
    ecc_rsp_t exp_rsp;
    int       due;
    string    nm;

    `include "ecc_ref_model.svh"

    ecc_109_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s expected=%h actual=%h", name, exp, act);
            errors++;
        end
    endtask

    function automatic string test_name(input int kind);
        case (kind)
            0:       return "clean";
            1:       return "single_data";
            2:       return "single_check";
            3:       return "double";
            default: return "bypass";
        endcase
    endfunction

    function automatic int pick_index(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic data_t random_data();
        logic [127:0] wide;
        wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return wide[DATA_WIDTH-1:0];
    endfunction

    function automatic ecc_req_t make_request(input int kind);
        ecc_req_t                r;
        logic [CODE_WIDTH-1:0]   code;
        int                      a;
        int                      b;
        r.data      = random_data();
        r.parity_in = model_check(r.data);
        r.bypass    = 1'b0;
        case (kind)
            1: begin
                a         = pick_index(DATA_WIDTH);
                r.data[a] = ~r.data[a];
            end
            2: begin
                a              = pick_index(PARITY_WIDTH);
                r.parity_in[a] = ~r.parity_in[a];
            end
            3: begin
                // two distinct positions over the whole code word
                code = {r.parity_in, r.data};
                a    = pick_index(CODE_WIDTH);
                b    = pick_index(CODE_WIDTH - 1);
                if (b >= a) begin
                    b++;
                end
                code[a]     = ~code[a];
                code[b]     = ~code[b];
                r.data      = code[DATA_WIDTH-1:0];
                r.parity_in = code[CODE_WIDTH-1:DATA_WIDTH];
            end
            4: begin
                a           = pick_index(DATA_WIDTH);
                r.data[a]   = ~r.data[a];
                r.parity_in = parity_t'($random(seed));
                r.bypass    = 1'b1;
            end
            default: ;
        endcase
        return r;
    endfunction

    // strobes with random idle gaps
    // a zero gap gives back to back requests
    task automatic run_test(input int kind);
        ecc_req_t r;
        int       gap;
        for (int n = 0; n < N_PER_TEST; n++) begin
            r = make_request(kind);
            @(posedge clk);
            req       <= r;
            req_valid <= 1'b1;
            req_kind  <= kind;
            gap = pick_index(MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk);
                req_valid <= 1'b0;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // scoreboard samples half a cycle away from the driving edge
    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("response at cycle %0d with no request outstanding", cyc);
                errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                due     = due_q.pop_front();
                nm      = test_name(kind_q.pop_front());
                check({nm, " latency"}, 128'(due), 128'(cyc));
                check({nm, " data"}, 128'(exp_rsp.data), 128'(rsp.data));
                check({nm, " parity_out"}, 128'(exp_rsp.parity_out), 128'(rsp.parity_out));
                check({nm, " sbit_err"}, 128'(exp_rsp.sbit_err), 128'(rsp.sbit_err));
                check({nm, " dbit_err"}, 128'(exp_rsp.dbit_err), 128'(rsp.dbit_err));
            end
        end
        if (req_valid === 1'b1) begin
            exp_q.push_back(model_response(req));
            due_q.push_back(cyc + 2);
            kind_q.push_back(req_kind);
        end
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed      = 32'h6ee3_afd9;
        errors    = 0;
        checks    = 0;
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        req_kind  <= 0;
        init_model_columns();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset rsp_valid", '0, 128'(rsp_valid));
        check("reset sbit_err", '0, 128'(rsp.sbit_err));
        check("reset dbit_err", '0, 128'(rsp.dbit_err));
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few quiet cycles to catch stray responses
        repeat (4) @(posedge clk);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+dv
rtl/ecc_code_pkg.sv
rtl/ecc_bus_pkg.sv
rtl/ecc_parity_gen.sv
rtl/ecc_syndrome_decode.sv
rtl/ecc_109_top.sv
dv/ecc_109_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ecc testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module ecc_109_tb \
    -f tb.f \
    -o ecc_sim

./obj_dir/ecc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
